/* frontend_macros.svh */
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// entries in the instruction queue
`define IQ_DEPTH 8

// issue credits granted by the back end out of reset
`define IQ_CREDITS 4

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

/* rv32i_pkg.sv */
package rv32i_pkg;

    // one instruction, address or data word
    typedef logic [31:0] word_t;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } opcode_t;

    // funct3 of the load group
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // funct3 of the store group
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

endpackage : rv32i_pkg

/* tomasulo_pkg.sv */
package tomasulo_pkg;

    // micro-ops understood by the reservation stations
    typedef enum logic [3:0] {
        ARITH,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BRANCH,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } uop_t;

    // one instruction queue entry
    typedef struct packed {
        uop_t               op;
        logic [4:0]         src1_reg;
        logic [4:0]         src2_reg;
        logic [4:0]         rd;
        logic               src2_valid;
        rv32i_pkg::word_t   src2_data;
        logic [2:0]         funct3;
        logic               funct7b;
        // result for lui/auipc/links, taken target for branches
        rv32i_pkg::word_t   target;
        rv32i_pkg::word_t   og_pc;
    } ctrl_word_t;

endpackage : tomasulo_pkg

/* pc_unit.sv */
`timescale 1ns/1ps

`include "frontend_macros.svh"

module pc_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              ld_pc,
    input  rv32i_pkg::word_t  next_pc,
    input  logic              jalr_done,
    input  rv32i_pkg::word_t  jalr_target,
    input  logic              flush,
    input  rv32i_pkg::word_t  flush_pc,
    output rv32i_pkg::word_t  pc
);

    import rv32i_pkg::*;

    word_t pc_next;
    logic  pc_load;

    // back end redirects win over the decoder
    always_comb begin
        pc_load = 1'b1;
        pc_next = pc;
        if (flush) begin
            pc_next = flush_pc;
        end else if (jalr_done) begin
            pc_next = jalr_target;
        end else if (ld_pc) begin
            pc_next = next_pc;
        end else begin
            pc_load = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (pc_load) begin
            pc <= pc_next;
        end
    end

    // redirect addresses come from the back end as well as the decoder
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (rst)
        pc_load |=> (pc[1:0] == 2'b00)
    ) else $error("pc loaded with unaligned address %h", pc);

endmodule : pc_unit

/* instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  logic                clk,
    input  logic                rst,
    input  rv32i_pkg::word_t    pc,
    input  logic                imem_resp,
    input  rv32i_pkg::word_t    imem_rdata,
    input  logic                iq_ack,
    input  logic                jalr_done,
    input  logic                flush,
    output logic                imem_read,
    output logic                ld_pc,
    output rv32i_pkg::word_t    next_pc,
    output logic                iq_load,
    output tomasulo_pkg::uop_t  op,
    output logic [4:0]          src1_reg,
    output logic [4:0]          src2_reg,
    output logic [4:0]          rd,
    output logic                src2_valid,
    output rv32i_pkg::word_t    src2_data,
    output logic [2:0]          funct3,
    output logic                funct7b,
    output rv32i_pkg::word_t    target,
    output rv32i_pkg::word_t    og_pc
);

    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    typedef enum logic [2:0] {
        RESET,
        FETCH,
        CREATE,
        STALL,
        JALR_WAIT,
        FLUSH_WAIT
    } state_t;

    state_t  state;
    state_t  state_next;

    // fetched word and the address it came from
    word_t   instr;
    word_t   instr_pc;

    opcode_t opcode;
    word_t   i_imm;
    word_t   s_imm;
    word_t   b_imm;
    word_t   u_imm;
    word_t   j_imm;

    assign opcode = opcode_t'(instr[6:0]);
    assign i_imm  = {{21{instr[31]}}, instr[30:20]};
    assign s_imm  = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm  = {instr[31:12], 12'h000};
    assign j_imm  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // the pc moves on in CREATE, so fields use the captured address
    always_ff @(posedge clk) begin
        if (state == FETCH && imem_resp) begin
            instr    <= imem_rdata;
            instr_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        if (flush) begin
            state_next = FLUSH_WAIT;
        end else begin
            case (state)
                RESET:      state_next = FETCH;
                FETCH:      if (imem_resp) state_next = CREATE;
                CREATE, STALL: begin
                    if (iq_ack) begin
                        state_next = (opcode == op_jalr) ? JALR_WAIT : FETCH;
                    end else begin
                        state_next = STALL;
                    end
                end
                JALR_WAIT:  if (jalr_done) state_next = FETCH;
                FLUSH_WAIT: state_next = FETCH;
                default:    state_next = RESET;
            endcase
        end
    end

    // a flush abandons an outstanding fetch when imem_read falls
    assign imem_read = (state == FETCH);
    assign ld_pc     = (state == CREATE);
    assign iq_load   = (state == CREATE) || (state == STALL);

    // jal redirects, everything else falls through
    // a jalr also loads pc+4 here but is refetched only after jalr_done
    assign next_pc = (opcode == op_jal) ? instr_pc + j_imm : instr_pc + 32'd4;

    always_comb begin
        op         = ARITH;
        src1_reg   = instr[19:15];
        src2_reg   = instr[24:20];
        rd         = instr[11:7];
        src2_valid = 1'b0;
        src2_data  = '0;
        funct3     = instr[14:12];
        funct7b    = instr[30];
        target     = instr_pc + 32'd4;
        og_pc      = instr_pc;
        case (opcode)
            op_lui, op_auipc, op_jal: begin
                src1_reg   = '0;
                src2_reg   = '0;
                src2_valid = 1'b1;
                if (opcode == op_lui) begin
                    op     = LUI;
                    target = u_imm;
                end else if (opcode == op_auipc) begin
                    op     = AUIPC;
                    target = instr_pc + u_imm;
                end else begin
                    op     = JAL;
                end
            end
            op_br: begin
                // predicted not taken, keep the taken target for the back end
                op     = BRANCH;
                rd     = '0;
                target = instr_pc + b_imm;
            end
            op_store: begin
                // src2_reg is the store data, the immediate forms the address
                case (store_funct3_t'(instr[14:12]))
                    sb:      op = SB;
                    sh:      op = SH;
                    default: op = SW;
                endcase
                rd         = '0;
                src2_valid = 1'b1;
                src2_data  = s_imm;
            end
            op_load, op_imm, op_csr, op_jalr: begin
                if (opcode == op_load) begin
                    case (load_funct3_t'(instr[14:12]))
                        lb:      op = LB;
                        lh:      op = LH;
                        lbu:     op = LBU;
                        lhu:     op = LHU;
                        default: op = LW;
                    endcase
                end else if (opcode == op_jalr) begin
                    op = JALR;
                end
                src2_reg   = '0;
                src2_valid = 1'b1;
                src2_data  = i_imm;
            end
            default: ;
        endcase
    end

    a_no_load_in_fetch : assert property (
        @(posedge clk) disable iff (rst)
        (state == FETCH) |-> !iq_load
    ) else $error("iq_load raised while fetching");

    // the pc unit must hold the fetch address for the whole read
    a_addr_stable : assert property (
        @(posedge clk) disable iff (rst)
        (imem_read && !imem_resp && !flush && !jalr_done) |=> $stable(pc)
    ) else $error("fetch address changed during a read");

endmodule : instr_decoder

/* instr_queue.sv */
`timescale 1ns/1ps

`include "frontend_macros.svh"

module instr_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                iq_load,
    input  tomasulo_pkg::uop_t  op,
    input  logic [4:0]          src1_reg,
    input  logic [4:0]          src2_reg,
    input  logic [4:0]          rd,
    input  logic                src2_valid,
    input  rv32i_pkg::word_t    src2_data,
    input  logic [2:0]          funct3,
    input  logic                funct7b,
    input  rv32i_pkg::word_t    target,
    input  rv32i_pkg::word_t    og_pc,
    input  logic                credit_return,
    output logic                iq_ack,
    output logic                issue_valid,
    output tomasulo_pkg::uop_t  issue_op,
    output logic [4:0]          issue_src1_reg,
    output logic [4:0]          issue_src2_reg,
    output logic [4:0]          issue_rd,
    output logic                issue_src2_valid,
    output rv32i_pkg::word_t    issue_src2_data,
    output logic [2:0]          issue_funct3,
    output logic                issue_funct7b,
    output rv32i_pkg::word_t    issue_target,
    output rv32i_pkg::word_t    issue_og_pc
);

    import tomasulo_pkg::*;

    localparam int DEPTH  = `IQ_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`IQ_CREDITS + 1);

    ctrl_word_t         mem [DEPTH];
    ctrl_word_t         wr_word;
    ctrl_word_t         rd_word;
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [CNT_W-1:0]   count;
    logic [CRED_W-1:0]  credits;
    logic               full;
    logic               wr;

    assign full   = (count == CNT_W'(DEPTH));
    assign iq_ack = !full && !flush;
    assign wr     = iq_load && iq_ack;

    assign wr_word = '{op: op, src1_reg: src1_reg, src2_reg: src2_reg, rd: rd,
                       src2_valid: src2_valid, src2_data: src2_data, funct3: funct3,
                       funct7b: funct7b, target: target, og_pc: og_pc};

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[tail] <= wr_word;
        end
    end

    // entries already in the queue are stale once a flush is seen
    assign issue_valid = (count != '0) && (credits != '0) && !flush;
    assign rd_word     = mem[head];

    assign issue_op         = rd_word.op;
    assign issue_src1_reg   = rd_word.src1_reg;
    assign issue_src2_reg   = rd_word.src2_reg;
    assign issue_rd         = rd_word.rd;
    assign issue_src2_valid = rd_word.src2_valid;
    assign issue_src2_data  = rd_word.src2_data;
    assign issue_funct3     = rd_word.funct3;
    assign issue_funct7b    = rd_word.funct7b;
    assign issue_target     = rd_word.target;
    assign issue_og_pc      = rd_word.og_pc;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wr) begin
                tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (issue_valid) begin
                head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({wr, issue_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // credits survive a flush because squashed entries come back through credit_return
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(`IQ_CREDITS);
        end else begin
            case ({issue_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // the back end never hands back more than it was given
    a_credit_bound : assert property (
        @(posedge clk) disable iff (rst)
        credit_return |=> (credits <= CRED_W'(`IQ_CREDITS))
    ) else $error("credit count above %0d", `IQ_CREDITS);

    // a write never lands on the live head entry
    a_no_write_full : assert property (
        @(posedge clk) disable iff (rst)
        wr |-> ((count == '0) || (tail != head))
    ) else $error("instruction queue written while full");

endmodule : instr_queue

/* frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                imem_resp,
    input  rv32i_pkg::word_t    imem_rdata,
    input  logic                jalr_done,
    input  rv32i_pkg::word_t    jalr_target,
    input  logic                flush,
    input  rv32i_pkg::word_t    flush_pc,
    input  logic                credit_return,
    output logic                imem_read,
    output rv32i_pkg::word_t    imem_addr,
    output logic                issue_valid,
    output tomasulo_pkg::uop_t  issue_op,
    output logic [4:0]          issue_src1_reg,
    output logic [4:0]          issue_src2_reg,
    output logic [4:0]          issue_rd,
    output logic                issue_src2_valid,
    output rv32i_pkg::word_t    issue_src2_data,
    output logic [2:0]          issue_funct3,
    output logic                issue_funct7b,
    output rv32i_pkg::word_t    issue_target,
    output rv32i_pkg::word_t    issue_og_pc
);

    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    word_t       pc;
    word_t       next_pc;
    logic        ld_pc;
    logic        iq_load;
    logic        iq_ack;

    // control word from decoder to queue
    uop_t        op;
    logic [4:0]  src1_reg;
    logic [4:0]  src2_reg;
    logic [4:0]  rd;
    logic        src2_valid;
    word_t       src2_data;
    logic [2:0]  funct3;
    logic        funct7b;
    word_t       target;
    word_t       og_pc;

    assign imem_addr = pc;

    pc_unit u_pc_unit (
        .clk         (clk),
        .rst         (rst),
        .ld_pc       (ld_pc),
        .next_pc     (next_pc),
        .jalr_done   (jalr_done),
        .jalr_target (jalr_target),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .pc          (pc)
    );

    instr_decoder u_instr_decoder (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .imem_resp  (imem_resp),
        .imem_rdata (imem_rdata),
        .iq_ack     (iq_ack),
        .jalr_done  (jalr_done),
        .flush      (flush),
        .imem_read  (imem_read),
        .ld_pc      (ld_pc),
        .next_pc    (next_pc),
        .iq_load    (iq_load),
        .op         (op),
        .src1_reg   (src1_reg),
        .src2_reg   (src2_reg),
        .rd         (rd),
        .src2_valid (src2_valid),
        .src2_data  (src2_data),
        .funct3     (funct3),
        .funct7b    (funct7b),
        .target     (target),
        .og_pc      (og_pc)
    );

    instr_queue u_instr_queue (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .iq_load          (iq_load),
        .op               (op),
        .src1_reg         (src1_reg),
        .src2_reg         (src2_reg),
        .rd               (rd),
        .src2_valid       (src2_valid),
        .src2_data        (src2_data),
        .funct3           (funct3),
        .funct7b          (funct7b),
        .target           (target),
        .og_pc            (og_pc),
        .credit_return    (credit_return),
        .iq_ack           (iq_ack),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .issue_src1_reg   (issue_src1_reg),
        .issue_src2_reg   (issue_src2_reg),
        .issue_rd         (issue_rd),
        .issue_src2_valid (issue_src2_valid),
        .issue_src2_data  (issue_src2_data),
        .issue_funct3     (issue_funct3),
        .issue_funct7b    (issue_funct7b),
        .issue_target     (issue_target),
        .issue_og_pc      (issue_og_pc)
    );

endmodule : frontend_top

/* tb_frontend_ref.svh */
`ifndef TB_FRONTEND_REF_SVH
`define TB_FRONTEND_REF_SVH

function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// words outside the program, never expected to be fetched
function automatic word_t read_word(word_t addr);
    logic [11:0] mix;
    if (imem.exists(addr)) begin
        return imem[addr];
    end
    mix = addr[31:20] ^ addr[19:8] ^ {addr[7:0], 4'h0};
    return {mix, 5'd0, 3'b000, 5'd0, op_imm};
endfunction

function automatic word_t rand_insn();
    logic [31:0] r;
    logic [31:0] k;
    logic [2:0]  f3;
    r = rand32();
    k = rand32() % 32'd6;
    case (k)
        32'd0:   return {r[31:7], op_imm};
        32'd1:   return {1'b0, r[30], 5'd0, r[24:7], op_reg};
        32'd2: begin
            case (r[2:0] % 3'd5)
                3'd0:    f3 = 3'b000;
                3'd1:    f3 = 3'b001;
                3'd2:    f3 = 3'b010;
                3'd3:    f3 = 3'b100;
                default: f3 = 3'b101;
            endcase
            return {r[31:15], f3, r[11:7], op_load};
        end
        32'd3: begin
            f3 = r[13:12] == 2'd3 ? 3'b010 : {1'b0, r[13:12]};
            return {r[31:15], f3, r[11:7], op_store};
        end
        32'd4:   return {r[31:7], op_lui};
        default: return {r[31:7], op_auipc};
    endcase
endfunction

function automatic word_t enc_jal(logic [4:0] rd, word_t off);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

function automatic word_t enc_jalr(logic [31:0] r);
    return {r[31:15], 3'b000, r[11:7], op_jalr};
endfunction

function automatic word_t enc_branch(logic [31:0] r);
    logic [2:0] f3;
    f3 = (r[14:13] == 2'b01) ? 3'b100 : r[14:12];
    return {r[31:25], r[24:15], f3, r[11:7], op_br};
endfunction

// expected control word, straight from the RV32I field layout
function automatic ctrl_word_t decode_ref(word_t w, word_t pc);
    ctrl_word_t c;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'h000};
    c.op         = ARITH;
    c.src1_reg   = w[19:15];
    c.src2_reg   = w[24:20];
    c.rd         = w[11:7];
    c.src2_valid = 1'b0;
    c.src2_data  = '0;
    c.funct3     = w[14:12];
    c.funct7b    = w[30];
    c.target     = pc + 32'd4;
    c.og_pc      = pc;
    case (w[6:0])
        op_lui, op_auipc, op_jal: begin
            c.op         = (w[6:0] == op_lui) ? LUI : (w[6:0] == op_auipc) ? AUIPC : JAL;
            c.src1_reg   = '0;
            c.src2_reg   = '0;
            c.src2_valid = 1'b1;
            if (w[6:0] == op_lui) begin
                c.target = imm_u;
            end else if (w[6:0] == op_auipc) begin
                c.target = pc + imm_u;
            end
        end
        op_br: begin
            c.op     = BRANCH;
            c.rd     = '0;
            c.target = pc + imm_b;
        end
        op_store: begin
            c.op         = (w[14:12] == 3'b000) ? SB : (w[14:12] == 3'b001) ? SH : SW;
            c.rd         = '0;
            c.src2_valid = 1'b1;
            c.src2_data  = imm_s;
        end
        op_load, op_imm, op_csr, op_jalr: begin
            if (w[6:0] == op_jalr) begin
                c.op = JALR;
            end else if (w[6:0] == op_load) begin
                case (w[14:12])
                    3'b000:  c.op = LB;
                    3'b001:  c.op = LH;
                    3'b100:  c.op = LBU;
                    3'b101:  c.op = LHU;
                    default: c.op = LW;
                endcase
            end
            c.src2_reg   = '0;
            c.src2_valid = 1'b1;
            c.src2_data  = imm_i;
        end
        default: ;
    endcase
    return c;
endfunction

task automatic put_word(int seg, word_t addr, word_t w);
    imem[addr] = w;
    exp_q.push_back(decode_ref(w, addr));
    exp_seg_q.push_back(seg);
    fetch_q.push_back(addr);
    fetch_seg_q.push_back(seg);
endtask

// walks each segment in fetch order, every segment ends in a jalr
task automatic build_program();
    word_t a;
    int    n;
    seg_name = '{"straight_line", "jal_redirect", "branch_not_taken",
                 "credit_backpressure", "flush_stale", "after_flush"};
    for (int s = 0; s < NSEG; s++) begin
        seg_start[s]   = 32'h1000 * s;
        issued_cnt[s]  = 0;
        jalr_issued[s] = 1'b0;
        a = seg_start[s];
        n = (s == 3) ? 16 : (s == 4) ? 20 : (s == 5) ? 6 : 10;
        for (int i = 0; i < n; i++) begin
            if (s == 1 && i == 4) begin
                put_word(s, a, enc_jal(5'(rand32()), 32'h40));
                a = a + 32'h40;
            end else if (s == 2 && i[0]) begin
                put_word(s, a, enc_branch(rand32()));
                a = a + 32'd4;
            end else begin
                put_word(s, a, rand_insn());
                a = a + 32'd4;
            end
        end
        put_word(s, a, enc_jalr(rand32()));
    end
endtask

task automatic check_fetch(word_t addr);
    if (fetch_q.size() == 0) begin
        stop_with_fail($sformatf("fetch from %h while no fetch was expected", addr));
    end else begin
        check_word({seg_name[fetch_seg_q[0]], " fetch addr"}, fetch_q[0], addr);
        void'(fetch_q.pop_front());
        void'(fetch_seg_q.pop_front());
    end
endtask

task automatic check_uop(string name, uop_t exp, uop_t act);
    if (exp !== act) begin
        stop_with_fail($sformatf("Mismatch %s: expected %s, actual %s",
                                 name, exp.name(), act.name()));
    end
endtask

task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
        stop_with_fail($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_reg(string name, logic [4:0] exp, logic [4:0] act);
    if (exp !== act) begin
        stop_with_fail($sformatf("Mismatch %s: expected x%0d, actual x%0d", name, exp, act));
    end
endtask

task automatic compare_entry(string name, ctrl_word_t e);
    check_word({name, " og_pc"}, e.og_pc, issue_og_pc);
    check_uop({name, " op"}, e.op, issue_op);
    check_reg({name, " src1_reg"}, e.src1_reg, issue_src1_reg);
    check_reg({name, " src2_reg"}, e.src2_reg, issue_src2_reg);
    check_reg({name, " rd"}, e.rd, issue_rd);
    check_word({name, " src2_valid"}, 32'(e.src2_valid), 32'(issue_src2_valid));
    check_word({name, " src2_data"}, e.src2_data, issue_src2_data);
    check_word({name, " funct3"}, 32'(e.funct3), 32'(issue_funct3));
    check_word({name, " funct7b"}, 32'(e.funct7b), 32'(issue_funct7b));
    check_word({name, " target"}, e.target, issue_target);
endtask

`endif

/* tb_frontend.sv */
`timescale 1ns/1ps

`include "frontend_macros.svh"

module tb_frontend;

    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    localparam int TIMEOUT = 3000;
    localparam int NSEG    = 6;

    logic        clk;
    logic        rst;
    logic        imem_resp;
    word_t       imem_rdata;
    logic        jalr_done;
    word_t       jalr_target;
    logic        flush;
    word_t       flush_pc;
    logic        credit_return;
    logic        imem_read;
    word_t       imem_addr;
    logic        issue_valid;
    uop_t        issue_op;
    logic [4:0]  issue_src1_reg;
    logic [4:0]  issue_src2_reg;
    logic [4:0]  issue_rd;
    logic        issue_src2_valid;
    word_t       issue_src2_data;
    logic [2:0]  issue_funct3;
    logic        issue_funct7b;
    word_t       issue_target;
    word_t       issue_og_pc;

    // program image and expected streams, built before reset is released
    word_t       imem [word_t];
    ctrl_word_t  exp_q [$];
    int          exp_seg_q [$];
    word_t       fetch_q [$];
    int          fetch_seg_q [$];
    string       seg_name [NSEG];
    word_t       seg_start [NSEG];
    int          issued_cnt [NSEG];
    bit          jalr_issued [NSEG];

    logic [31:0] lcg_state = 32'hbfbd_9f0f;
    int          owed;
    bit          hold;
    bit          slow;
    int          errors;

    frontend_top u_frontend_top (
        .clk              (clk),
        .rst              (rst),
        .imem_resp        (imem_resp),
        .imem_rdata       (imem_rdata),
        .jalr_done        (jalr_done),
        .jalr_target      (jalr_target),
        .flush            (flush),
        .flush_pc         (flush_pc),
        .credit_return    (credit_return),
        .imem_read        (imem_read),
        .imem_addr        (imem_addr),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .issue_src1_reg   (issue_src1_reg),
        .issue_src2_reg   (issue_src2_reg),
        .issue_rd         (issue_rd),
        .issue_src2_valid (issue_src2_valid),
        .issue_src2_data  (issue_src2_data),
        .issue_funct3     (issue_funct3),
        .issue_funct7b    (issue_funct7b),
        .issue_target     (issue_target),
        .issue_og_pc      (issue_og_pc)
    );

    `include "tb_frontend_ref.svh"

    task automatic stop_with_fail(string what);
        errors++;
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "first error seen");
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory model, a new read is seen on the falling edge
    initial begin : mem_model
        bit    pending;
        bit    fire;
        int    wait_left;
        word_t fetch_addr;
        pending = 1'b0;
        forever begin
            @(negedge clk);
            fire = 1'b0;
            if (rst || !imem_read) begin
                pending = 1'b0;
            end else if (!pending) begin
                pending    = 1'b1;
                fetch_addr = imem_addr;
                wait_left  = int'(rand32() % 32'd4);
                check_fetch(fetch_addr);
            end
            if (pending && imem_read && !imem_resp) begin
                if (wait_left == 0) begin
                    fire = 1'b1;
                end else begin
                    wait_left--;
                end
            end
            @(posedge clk);
            imem_resp <= fire;
            if (fire) begin
                imem_rdata <= read_word(fetch_addr);
            end
        end
    end

    // back end stand-in, hands credits back after random delays
    initial begin : consumer
        logic [31:0] r;
        forever begin
            @(posedge clk);
            r = rand32();
            if (!rst && !hold && owed > 0 && (slow ? r[2:0] == 3'd0 : r[1:0] != 2'd0)) begin
                credit_return <= 1'b1;
                owed--;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    initial begin : compare_issue
        ctrl_word_t exp;
        int         seg;
        forever begin
            @(negedge clk);
            if (!rst && issue_valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_fail("an entry issued while none was expected");
                end else begin
                    exp = exp_q.pop_front();
                    seg = exp_seg_q.pop_front();
                    compare_entry(seg_name[seg], exp);
                    issued_cnt[seg]++;
                    owed++;
                    if (owed > `IQ_CREDITS) begin
                        stop_with_fail("outstanding issues went above the credit count");
                    end
                    if (exp.op == JALR) begin
                        jalr_issued[seg] = 1'b1;
                    end
                end
            end
        end
    end

    task automatic resolve_jalr(int seg);
        int cycles;
        cycles = 0;
        while (!jalr_issued[seg]) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_fail({"timeout waiting for the jalr of ", seg_name[seg]});
            end
        end
        // fetch must stay quiet until the target comes back
        repeat (6) begin
            @(negedge clk);
            if (imem_read) begin
                stop_with_fail({"fetch started before jalr_done in ", seg_name[seg]});
            end
        end
        @(posedge clk);
        jalr_done   <= 1'b1;
        jalr_target <= seg_start[seg + 1];
        @(posedge clk);
        jalr_done   <= 1'b0;
    endtask

    task automatic flush_segment(int seg, int next_seg);
        int cycles;
        cycles = 0;
        while (issued_cnt[seg] == 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_fail({"timeout waiting for an issue from ", seg_name[seg]});
            end
        end
        // let entries pile up in the queue, then throw them away
        hold = 1'b1;
        repeat (20) @(posedge clk);
        flush    <= 1'b1;
        flush_pc <= seg_start[next_seg];
        @(posedge clk);
        flush    <= 1'b0;
        @(negedge clk);
        while (exp_seg_q.size() > 0 && exp_seg_q[0] == seg) begin
            void'(exp_q.pop_front());
            void'(exp_seg_q.pop_front());
        end
        while (fetch_seg_q.size() > 0 && fetch_seg_q[0] == seg) begin
            void'(fetch_q.pop_front());
            void'(fetch_seg_q.pop_front());
        end
        hold = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_fail("timeout waiting for the remaining entries to issue");
            end
        end
        // nothing more may show up afterwards
        repeat (30) @(negedge clk);
        if (fetch_q.size() != 0) begin
            stop_with_fail("an expected fetch address was never read");
        end
    endtask

    initial begin
        rst           = 1'b1;
        imem_resp     = 1'b0;
        imem_rdata    = '0;
        jalr_done     = 1'b0;
        jalr_target   = '0;
        flush         = 1'b0;
        flush_pc      = '0;
        credit_return = 1'b0;
        owed          = 0;
        hold          = 1'b0;
        slow          = 1'b0;
        errors        = 0;
        build_program();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        resolve_jalr(0);
        resolve_jalr(1);
        resolve_jalr(2);
        slow = 1'b1;
        resolve_jalr(3);
        slow = 1'b0;
        flush_segment(4, 5);
        wait_drain();
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_frontend

/* filelist.f */
+incdir+.
rv32i_pkg.sv
tomasulo_pkg.sv
pc_unit.sv
instr_decoder.sv
instr_queue.sv
frontend_top.sv
tb_frontend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_frontend
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f filelist.f --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
